/* rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// reorder buffer depth
// kept a power of two so head and tail wrap on their own
`define ROB_SIZE 8

// dispatch and retire slots per cycle
`define ISSUE_WIDTH 2

// result broadcast ports
`define CDB_PORTS 2

// register file sizes
`define PHYS_REGS 64
`define ARCH_REGS 32

// branch queue and store queue depth
`define BRANCH_SLOTS 4
`define SQ_SLOTS 8

// instruction address width
`define PC_WIDTH 32

`endif

/* rob_pkg.sv */
`include "rob_config.svh"

package rob_pkg;

	// physical register tag
	typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;

	// architectural register index
	typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

	// entry index into the buffer
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

	// occupancy, 0 up to full
	typedef logic [$clog2(`ROB_SIZE+1)-1:0] rob_count_t;

	// branch queue slot
	typedef logic [$clog2(`BRANCH_SLOTS)-1:0] br_slot_t;

	// store queue slot
	typedef logic [$clog2(`SQ_SLOTS)-1:0] sq_slot_t;

	// instruction address
	typedef logic [`PC_WIDTH-1:0] pc_t;

	// one bit per entry
	typedef logic [`ROB_SIZE-1:0] entry_mask_t;

endpackage

/* tag_cam.sv */
`include "rob_config.svh"

module tag_cam (
	// result broadcast ports
	input  logic [`CDB_PORTS-1:0]                 cdb_valid,
	input  rob_pkg::phys_tag_t [`CDB_PORTS-1:0] cdb_tag,
	// destination tag of every entry
	input  rob_pkg::phys_tag_t [`ROB_SIZE-1:0]  entry_t_new,
	// entries named by some valid port
	output rob_pkg::entry_mask_t                  tag_hit
);

	import rob_pkg::*;

	// per port compare result across all entries
	entry_mask_t port_hit [`CDB_PORTS];

	// full compare, every port against every entry
	always_comb begin
		for (int p = 0; p < `CDB_PORTS; p++) begin
			for (int e = 0; e < `ROB_SIZE; e++) begin
				// idle port never hits
				port_hit[p][e] = cdb_valid[p] & (cdb_tag[p] == entry_t_new[e]);
			end
		end
	end

	// or the ports together per entry
	always_comb begin
		tag_hit = '0;
		for (int p = 0; p < `CDB_PORTS; p++) begin
			tag_hit = tag_hit | port_hit[p];
		end
	end

endmodule

/* resolve_match.sv */
`include "rob_config.svh"

module resolve_match (
	// branch resolution, one per cycle
	input  logic                                  br_valid,
	input  rob_pkg::br_slot_t                     br_slot,
	input  rob_pkg::br_slot_t [`ROB_SIZE-1:0]   entry_br_slot,
	// store completion, one per cycle
	input  logic                                  sq_valid,
	input  rob_pkg::sq_slot_t                     sq_slot,
	input  rob_pkg::sq_slot_t [`ROB_SIZE-1:0]   entry_sq_slot,
	// entries named by the resolving slots
	output rob_pkg::entry_mask_t                  br_hit,
	output rob_pkg::entry_mask_t                  sq_hit
);

	import rob_pkg::*;

	// raw slot compares, before the valid strobes
	entry_mask_t br_slot_eq;
	entry_mask_t sq_slot_eq;

	// branch slot compare per entry
	always_comb begin
		for (int e = 0; e < `ROB_SIZE; e++) begin
			br_slot_eq[e] = (entry_br_slot[e] == br_slot);
		end
	end

	// store queue slot compare per entry
	always_comb begin
		for (int e = 0; e < `ROB_SIZE; e++) begin
			sq_slot_eq[e] = (entry_sq_slot[e] == sq_slot);
		end
	end

	// kind of entry is not checked here
	// the buffer picks which vector applies
	assign br_hit = br_slot_eq & {`ROB_SIZE{br_valid}};
	assign sq_hit = sq_slot_eq & {`ROB_SIZE{sq_valid}};

endmodule

/* rob.sv */
`include "rob_config.svh"

module rob (
	input  logic                                  clock,
	input  logic                                  rst_n,
	input  logic                                  flush,
	// dispatch, slot 0 oldest
	input  logic [`ISSUE_WIDTH-1:0]               disp_valid,
	input  rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] disp_t_old,
	input  rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] disp_t_new,
	input  rob_pkg::arch_reg_t [`ISSUE_WIDTH-1:0] disp_dest,
	input  rob_pkg::pc_t [`ISSUE_WIDTH-1:0]       disp_npc,
	input  logic [`ISSUE_WIDTH-1:0]               disp_halt,
	input  logic [`ISSUE_WIDTH-1:0]               disp_done,
	input  logic [`ISSUE_WIDTH-1:0]               disp_is_branch,
	input  rob_pkg::br_slot_t [`ISSUE_WIDTH-1:0]  disp_br_slot,
	input  logic [`ISSUE_WIDTH-1:0]               disp_is_store,
	input  rob_pkg::sq_slot_t [`ISSUE_WIDTH-1:0]  disp_sq_slot,
	output logic [`ISSUE_WIDTH-1:0]               disp_accept,
	// branch outcome
	input  logic                                  br_taken,
	input  rob_pkg::pc_t                          br_target,
	// matcher results
	input  rob_pkg::entry_mask_t                  tag_hit,
	input  rob_pkg::entry_mask_t                  br_hit,
	input  rob_pkg::entry_mask_t                  sq_hit,
	// entry fields out to the matchers
	output rob_pkg::phys_tag_t [`ROB_SIZE-1:0]    entry_t_new,
	output rob_pkg::br_slot_t [`ROB_SIZE-1:0]     entry_br_slot,
	output rob_pkg::sq_slot_t [`ROB_SIZE-1:0]     entry_sq_slot,
	// retire, slot 0 oldest
	output logic [`ISSUE_WIDTH-1:0]               retire_valid,
	output rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] retire_t_old,
	output rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] retire_t_new,
	output rob_pkg::arch_reg_t [`ISSUE_WIDTH-1:0] retire_dest,
	output rob_pkg::pc_t [`ISSUE_WIDTH-1:0]       retire_npc,
	output logic [`ISSUE_WIDTH-1:0]               retire_taken,
	output logic [`ISSUE_WIDTH-1:0]               retire_halt,
	output rob_pkg::rob_count_t                   free_count
);

	import rob_pkg::*;

	// control bits per entry
	entry_mask_t busy_q, busy_d;
	entry_mask_t done_q, done_d;
	entry_mask_t is_br_q, is_br_d;
	entry_mask_t is_st_q, is_st_d;
	entry_mask_t taken_q, taken_d;

	// payload per entry
	phys_tag_t [`ROB_SIZE-1:0] t_old_q, t_old_d;
	phys_tag_t [`ROB_SIZE-1:0] t_new_q, t_new_d;
	arch_reg_t [`ROB_SIZE-1:0] dest_q, dest_d;
	pc_t [`ROB_SIZE-1:0]       npc_q, npc_d;
	entry_mask_t               halt_q, halt_d;
	br_slot_t [`ROB_SIZE-1:0]  br_slot_q, br_slot_d;
	sq_slot_t [`ROB_SIZE-1:0]  sq_slot_q, sq_slot_d;

	// pointers and occupancy
	rob_idx_t   head_q, head_d;
	rob_idx_t   tail_q, tail_d;
	rob_count_t count_q, count_d;

	// per entry completion, after kind select
	entry_mask_t hit_sel;

	// retire and dispatch bookkeeping
	rob_idx_t [`ISSUE_WIDTH-1:0] ret_idx;
	rob_idx_t [`ISSUE_WIDTH-1:0] disp_idx;
	rob_count_t                  n_ret;
	rob_count_t                  n_disp;
	logic                        ret_chain;

	// matchers see the registered fields
	assign entry_t_new   = t_new_q;
	assign entry_br_slot = br_slot_q;
	assign entry_sq_slot = sq_slot_q;

	// registered state only, no same cycle retire credit
	assign free_count = rob_count_t'(`ROB_SIZE) - count_q;

	always_comb begin
		// hold by default
		busy_d    = busy_q;
		done_d    = done_q;
		is_br_d   = is_br_q;
		is_st_d   = is_st_q;
		taken_d   = taken_q;
		t_old_d   = t_old_q;
		t_new_d   = t_new_q;
		dest_d    = dest_q;
		npc_d     = npc_q;
		halt_d    = halt_q;
		br_slot_d = br_slot_q;
		sq_slot_d = sq_slot_q;

		// completion, pick the hit vector by entry kind
		for (int e = 0; e < `ROB_SIZE; e++) begin
			if (is_br_q[e]) begin
				hit_sel[e] = br_hit[e];
			end else if (is_st_q[e]) begin
				hit_sel[e] = sq_hit[e];
			end else begin
				hit_sel[e] = tag_hit[e];
			end
			done_d[e] = done_q[e] | (busy_q[e] & hit_sel[e]);
			// taken branch overwrites the fall through pc
			if (busy_q[e] & is_br_q[e] & br_hit[e] & br_taken) begin
				taken_d[e] = 1'b1;
				npc_d[e]   = br_target;
			end
		end

		// in order retire from head, stop at first not done
		// flush blocks all retire this cycle
		ret_chain = ~flush;
		n_ret     = '0;
		for (int k = 0; k < `ISSUE_WIDTH; k++) begin
			ret_idx[k]      = head_q + rob_idx_t'(k);
			retire_valid[k] = ret_chain & busy_q[ret_idx[k]] & done_d[ret_idx[k]];
			ret_chain       = retire_valid[k];
			retire_t_old[k] = t_old_q[ret_idx[k]];
			retire_t_new[k] = t_new_q[ret_idx[k]];
			retire_dest[k]  = dest_q[ret_idx[k]];
			retire_halt[k]  = halt_q[ret_idx[k]];
			// same cycle branch capture shows here
			retire_npc[k]   = npc_d[ret_idx[k]];
			retire_taken[k] = taken_d[ret_idx[k]];
			if (retire_valid[k]) begin
				busy_d[ret_idx[k]] = 1'b0;
				done_d[ret_idx[k]] = 1'b0;
				n_ret = n_ret + rob_count_t'(1);
			end
		end

		// dispatch at consecutive tail positions
		// idle slot skipped, later slot still counts
		n_disp = '0;
		for (int k = 0; k < `ISSUE_WIDTH; k++) begin
			disp_idx[k]    = tail_q + rob_idx_t'(n_disp);
			disp_accept[k] = ~flush & disp_valid[k] & (n_disp < free_count);
			if (disp_accept[k]) begin
				busy_d[disp_idx[k]]    = 1'b1;
				done_d[disp_idx[k]]    = disp_done[k];
				is_br_d[disp_idx[k]]   = disp_is_branch[k];
				is_st_d[disp_idx[k]]   = disp_is_store[k];
				taken_d[disp_idx[k]]   = 1'b0;
				t_old_d[disp_idx[k]]   = disp_t_old[k];
				t_new_d[disp_idx[k]]   = disp_t_new[k];
				dest_d[disp_idx[k]]    = disp_dest[k];
				npc_d[disp_idx[k]]     = disp_npc[k];
				halt_d[disp_idx[k]]    = disp_halt[k];
				br_slot_d[disp_idx[k]] = disp_br_slot[k];
				sq_slot_d[disp_idx[k]] = disp_sq_slot[k];
				n_disp = n_disp + rob_count_t'(1);
			end
		end

		// pointers wrap naturally at depth 8
		head_d  = head_q + rob_idx_t'(n_ret);
		tail_d  = tail_q + rob_idx_t'(n_disp);
		count_d = count_q + n_disp - n_ret;

		// mispredict recovery empties the buffer
		if (flush) begin
			busy_d  = '0;
			done_d  = '0;
			is_br_d = '0;
			is_st_d = '0;
			taken_d = '0;
			head_d  = '0;
			tail_d  = '0;
			count_d = '0;
		end
	end

	// control state
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy_q  <= '0;
			done_q  <= '0;
			is_br_q <= '0;
			is_st_q <= '0;
			taken_q <= '0;
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			busy_q  <= busy_d;
			done_q  <= done_d;
			is_br_q <= is_br_d;
			is_st_q <= is_st_d;
			taken_q <= taken_d;
			head_q  <= head_d;
			tail_q  <= tail_d;
			count_q <= count_d;
		end
	end

	// payload fields per entry
	always_ff @(posedge clock) begin
		t_old_q   <= t_old_d;
		t_new_q   <= t_new_d;
		dest_q    <= dest_d;
		npc_q     <= npc_d;
		halt_q    <= halt_d;
		br_slot_q <= br_slot_d;
		sq_slot_q <= sq_slot_d;
	end

endmodule

/* rob_top.sv */
`include "rob_config.svh"

module rob_top (
	input  logic                                  clock,
	input  logic                                  rst_n,
	input  logic                                  flush,
	// dispatch
	input  logic [`ISSUE_WIDTH-1:0]               disp_valid,
	input  rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] disp_t_old,
	input  rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] disp_t_new,
	input  rob_pkg::arch_reg_t [`ISSUE_WIDTH-1:0] disp_dest,
	input  rob_pkg::pc_t [`ISSUE_WIDTH-1:0]       disp_npc,
	input  logic [`ISSUE_WIDTH-1:0]               disp_halt,
	input  logic [`ISSUE_WIDTH-1:0]               disp_done,
	input  logic [`ISSUE_WIDTH-1:0]               disp_is_branch,
	input  rob_pkg::br_slot_t [`ISSUE_WIDTH-1:0]  disp_br_slot,
	input  logic [`ISSUE_WIDTH-1:0]               disp_is_store,
	input  rob_pkg::sq_slot_t [`ISSUE_WIDTH-1:0]  disp_sq_slot,
	output logic [`ISSUE_WIDTH-1:0]               disp_accept,
	// result broadcast
	input  logic [`CDB_PORTS-1:0]                 cdb_valid,
	input  rob_pkg::phys_tag_t [`CDB_PORTS-1:0]   cdb_tag,
	// branch resolution
	input  logic                                  br_valid,
	input  rob_pkg::br_slot_t                     br_slot,
	input  logic                                  br_taken,
	input  rob_pkg::pc_t                          br_target,
	// store completion
	input  logic                                  sq_valid,
	input  rob_pkg::sq_slot_t                     sq_slot,
	// retire
	output logic [`ISSUE_WIDTH-1:0]               retire_valid,
	output rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] retire_t_old,
	output rob_pkg::phys_tag_t [`ISSUE_WIDTH-1:0] retire_t_new,
	output rob_pkg::arch_reg_t [`ISSUE_WIDTH-1:0] retire_dest,
	output rob_pkg::pc_t [`ISSUE_WIDTH-1:0]       retire_npc,
	output logic [`ISSUE_WIDTH-1:0]               retire_taken,
	output logic [`ISSUE_WIDTH-1:0]               retire_halt,
	output rob_pkg::rob_count_t                   free_count
);

	import rob_pkg::*;

	// match vectors into the buffer
	entry_mask_t tag_hit;
	entry_mask_t br_hit;
	entry_mask_t sq_hit;

	// entry fields out of the buffer
	phys_tag_t [`ROB_SIZE-1:0] entry_t_new;
	br_slot_t [`ROB_SIZE-1:0]  entry_br_slot;
	sq_slot_t [`ROB_SIZE-1:0]  entry_sq_slot;

	// broadcast tags against every entry
	tag_cam u_tag_cam (
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.entry_t_new (entry_t_new),
		.tag_hit     (tag_hit)
	);

	// branch and store slots against every entry
	resolve_match u_resolve_match (
		.br_valid      (br_valid),
		.br_slot       (br_slot),
		.entry_br_slot (entry_br_slot),
		.sq_valid      (sq_valid),
		.sq_slot       (sq_slot),
		.entry_sq_slot (entry_sq_slot),
		.br_hit        (br_hit),
		.sq_hit        (sq_hit)
	);

	// buffer combines the hits per entry kind
	rob u_rob (
		.clock          (clock),
		.rst_n          (rst_n),
		.flush          (flush),
		.disp_valid     (disp_valid),
		.disp_t_old     (disp_t_old),
		.disp_t_new     (disp_t_new),
		.disp_dest      (disp_dest),
		.disp_npc       (disp_npc),
		.disp_halt      (disp_halt),
		.disp_done      (disp_done),
		.disp_is_branch (disp_is_branch),
		.disp_br_slot   (disp_br_slot),
		.disp_is_store  (disp_is_store),
		.disp_sq_slot   (disp_sq_slot),
		.disp_accept    (disp_accept),
		.br_taken       (br_taken),
		.br_target      (br_target),
		.tag_hit        (tag_hit),
		.br_hit         (br_hit),
		.sq_hit         (sq_hit),
		.entry_t_new    (entry_t_new),
		.entry_br_slot  (entry_br_slot),
		.entry_sq_slot  (entry_sq_slot),
		.retire_valid   (retire_valid),
		.retire_t_old   (retire_t_old),
		.retire_t_new   (retire_t_new),
		.retire_dest    (retire_dest),
		.retire_npc     (retire_npc),
		.retire_taken   (retire_taken),
		.retire_halt    (retire_halt),
		.free_count     (free_count)
	);

endmodule

/* rob_tb_table.svh */
`ifndef ROB_TB_TABLE_SVH
`define ROB_TB_TABLE_SVH

// one row per clock cycle, slot 0 oldest
typedef struct packed {
	logic       flush;
	logic [1:0] dv;        // disp_valid per slot
	logic [7:0] id0, id1;  // instruction ids offered on each slot
	logic [3:0] k0, k1;    // kind bits {store, branch, halt, done}
	logic [1:0] cv;        // cdb_valid per port
	logic [7:0] c0, c1;    // ids whose tags are broadcast
	logic       bv, bt;    // branch resolve valid and taken
	logic [1:0] bs;
	logic       sv;
	logic [2:0] ss;
	logic [1:0] eacc;      // expected disp_accept
	logic [3:0] efree;     // expected free_count
	logic [1:0] erv;       // expected retire_valid
	logic [7:0] e0, e1;    // ids expected on the retire slots
	logic [1:0] etk, ehl;  // expected retire_taken and retire_halt
} row_t;

localparam int NUM_ROWS = 22;

// fl dv id0 id1 k0 k1  cv c0 c1  bv bt bs  sv ss  acc fr rv e0 e1 tk hl
row_t rows [NUM_ROWS] = '{
	// empty after reset
	'{0, 0,  0,  0, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  0, 8, 0,  0,  0, 0, 0},
	// pair completes on both ports, retires together
	'{0, 3,  1,  2, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  3, 8, 0,  0,  0, 0, 0},
	'{0, 0,  0,  0, 0, 0,  3, 1, 2,  0, 0, 0,  0, 0,  0, 6, 3,  1,  2, 0, 0},
	// younger first, then older releases both
	'{0, 3,  3,  4, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  3, 8, 0,  0,  0, 0, 0},
	'{0, 0,  0,  0, 0, 0,  1, 4, 0,  0, 0, 0,  0, 0,  0, 6, 0,  0,  0, 0, 0},
	'{0, 0,  0,  0, 0, 0,  2, 0, 3,  0, 0, 0,  0, 0,  0, 6, 3,  3,  4, 0, 0},
	// branch id 5 on slot 1, store id 6 on sq slot 6
	'{0, 3,  5,  6, 4, 8,  0, 0, 0,  0, 0, 0,  0, 0,  3, 8, 0,  0,  0, 0, 0},
	// tag hits are ignored by both
	'{0, 0,  0,  0, 0, 0,  3, 5, 6,  0, 0, 0,  0, 0,  0, 6, 0,  0,  0, 0, 0},
	// store done but blocked behind the branch
	'{0, 0,  0,  0, 0, 0,  0, 0, 0,  0, 0, 0,  1, 6,  0, 6, 0,  0,  0, 0, 0},
	'{0, 0,  0,  0, 0, 0,  0, 0, 0,  1, 1, 1,  0, 0,  0, 6, 3,  5,  6, 1, 0},
	// halt done at dispatch
	'{0, 1,  7,  0, 3, 0,  0, 0, 0,  0, 0, 0,  0, 0,  1, 8, 0,  0,  0, 0, 0},
	'{0, 0,  0,  0, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  0, 7, 1,  7,  0, 0, 1},
	// fill up, idle slot 0 still lets slot 1 in
	'{0, 3,  8,  9, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  3, 8, 0,  0,  0, 0, 0},
	'{0, 2,  0, 10, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  2, 6, 0,  0,  0, 0, 0},
	'{0, 3, 11, 12, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  3, 5, 0,  0,  0, 0, 0},
	'{0, 3, 13, 14, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  3, 3, 0,  0,  0, 0, 0},
	'{0, 3, 15, 16, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  1, 1, 0,  0,  0, 0, 0},
	// full, the head completes and frees one entry
	'{0, 3, 16, 17, 0, 0,  1, 8, 0,  0, 0, 0,  0, 0,  0, 0, 1,  8,  0, 0, 0},
	// flush while the head completes and one entry is free
	'{1, 3, 16, 17, 0, 0,  1, 9, 0,  0, 0, 0,  0, 0,  0, 1, 0,  0,  0, 0, 0},
	'{0, 3, 18, 19, 1, 1,  0, 0, 0,  0, 0, 0,  0, 0,  3, 8, 0,  0,  0, 0, 0},
	'{0, 0,  0,  0, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  0, 6, 3, 18, 19, 0, 0},
	'{0, 0,  0,  0, 0, 0,  0, 0, 0,  0, 0, 0,  0, 0,  0, 8, 0,  0,  0, 0, 0}
};

`endif

/* rob_tb.sv */
`include "rob_config.svh"

module rob_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rob_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 5;
	// sample 10 ns ahead of the rising edge
	localparam int CHECK_DELAY  = 40;

	`include "rob_tb_table.svh"

	localparam int TIMEOUT = (NUM_ROWS + RESET_CYCLES + 20) * CLK_PERIOD;

	logic clock = 1'b0;
	logic rst_n, flush;
	// dispatch side
	logic [`ISSUE_WIDTH-1:0] disp_valid, disp_halt, disp_done, disp_is_branch, disp_is_store;
	phys_tag_t [`ISSUE_WIDTH-1:0] disp_t_old, disp_t_new;
	arch_reg_t [`ISSUE_WIDTH-1:0] disp_dest;
	pc_t [`ISSUE_WIDTH-1:0]       disp_npc;
	br_slot_t [`ISSUE_WIDTH-1:0]  disp_br_slot;
	sq_slot_t [`ISSUE_WIDTH-1:0]  disp_sq_slot;
	// completion side
	logic [`CDB_PORTS-1:0]        cdb_valid;
	phys_tag_t [`CDB_PORTS-1:0]   cdb_tag;
	logic                         br_valid, br_taken, sq_valid;
	br_slot_t                     br_slot;
	pc_t                          br_target;
	sq_slot_t                     sq_slot;
	// DUT outputs
	logic [`ISSUE_WIDTH-1:0] disp_accept, retire_valid, retire_taken, retire_halt;
	phys_tag_t [`ISSUE_WIDTH-1:0] retire_t_old, retire_t_new;
	arch_reg_t [`ISSUE_WIDTH-1:0] retire_dest;
	pc_t [`ISSUE_WIDTH-1:0]       retire_npc;
	rob_count_t                   free_count;

	int errors = 0;
	int checks = 0;
	int row_idx = 0;

	rob_top u_rob_top (.*);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// new tags sit in the upper half of the register file
	function automatic phys_tag_t tag_of(input logic [7:0] id);
		return phys_tag_t'(id + 8'd32);
	endfunction

	// fall through pc, one word per id
	function automatic pc_t npc_of(input logic [7:0] id);
		return 32'h0000_1000 + {id, 2'b00};
	endfunction

	function automatic pc_t target_of(input br_slot_t slot);
		return 32'h0000_8000 + {slot, 4'h0};
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Error: row %0d %s expected 0x%h actual 0x%h",
				row_idx, name, expected, actual);
		end
	endtask

	// dispatch fields all follow from the instruction id
	task automatic apply_row(input row_t r);
		logic [1:0][7:0] id;
		logic [1:0][3:0] kind;
		id   = {r.id1, r.id0};
		kind = {r.k1, r.k0};
		flush      = r.flush;
		disp_valid = r.dv;
		for (int k = 0; k < `ISSUE_WIDTH; k++) begin
			disp_t_old[k]     = phys_tag_t'(id[k]);
			disp_t_new[k]     = tag_of(id[k]);
			disp_dest[k]      = arch_reg_t'(id[k]);
			disp_npc[k]       = npc_of(id[k]);
			disp_br_slot[k]   = br_slot_t'(id[k]);
			disp_sq_slot[k]   = sq_slot_t'(id[k]);
			disp_done[k]      = kind[k][0];
			disp_halt[k]      = kind[k][1];
			disp_is_branch[k] = kind[k][2];
			disp_is_store[k]  = kind[k][3];
		end
		cdb_valid  = r.cv;
		cdb_tag[0] = tag_of(r.c0);
		cdb_tag[1] = tag_of(r.c1);
		br_valid   = r.bv;
		br_taken   = r.bt;
		br_slot    = r.bs;
		br_target  = target_of(r.bs);
		sq_valid   = r.sv;
		sq_slot    = r.ss;
	endtask

	task automatic check_row(input row_t r);
		logic [1:0][7:0] eid;
		pc_t enpc;
		eid = {r.e1, r.e0};
		compare("disp_accept", r.eacc, disp_accept);
		compare("free_count", r.efree, free_count);
		compare("retire_valid", r.erv, retire_valid);
		for (int k = 0; k < `ISSUE_WIDTH; k++) begin
			if (r.erv[k]) begin
				// a taken branch carries the resolved target
				enpc = r.etk[k] ? target_of(r.bs) : npc_of(eid[k]);
				compare($sformatf("retire_t_old[%0d]", k), phys_tag_t'(eid[k]), retire_t_old[k]);
				compare($sformatf("retire_t_new[%0d]", k), tag_of(eid[k]), retire_t_new[k]);
				compare($sformatf("retire_dest[%0d]", k), arch_reg_t'(eid[k]), retire_dest[k]);
				compare($sformatf("retire_npc[%0d]", k), enpc, retire_npc[k]);
				compare($sformatf("retire_taken[%0d]", k), r.etk[k], retire_taken[k]);
				compare($sformatf("retire_halt[%0d]", k), r.ehl[k], retire_halt[k]);
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		apply_row(row_t'('0));
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			@(negedge clock);
			row_idx = i;
			apply_row(rows[i]);
			#(CHECK_DELAY);
			check_row(rows[i]);
		end
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT);
		$display("run timed out after %0d ns before the table was done", TIMEOUT);
		$display("Verification failed");
		$finish;
	end

endmodule

/* src.f */
+incdir+.
rob_pkg.sv
tag_cam.sv
resolve_match.sv
rob.sv
rob_top.sv
rob_tb.sv

/* Bender.yml */
package:
  name: rob

sources:
  - include_dirs:
      - .
    files:
      - rob_pkg.sv
      - tag_cam.sv
      - resolve_match.sv
      - rob.sv
      - rob_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rob_tb.sv
